// File: flist.f
logic/cache_pkg.sv
logic/cache_store.sv
logic/plru_tree.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim \
    || exit 1

// File: tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    localparam int NUM_REQS = 400;
    localparam int TIMEOUT  = 100;

    logic                clk = 1'b0;
    logic                rst;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::cpu_rsp_t cpu_rsp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp;

    integer seed = 32'h89b7;

    // Backing memory and the CPU view, both keyed by word address
    logic [31:0] mem_words    [logic [29:0]];
    logic [31:0] shadow_words [logic [29:0]];

    // Reference copy of the tag store and PLRU state
    logic [22:0] m_tag   [16][4];
    logic        m_valid [16][4];
    logic        m_dirty [16][4];
    logic [2:0]  m_plru  [16];

    // What the memory side should see for the current request
    logic             exp_wb;
    cache_pkg::addr_t exp_wb_addr;
    cache_pkg::line_u exp_wb_line;
    cache_pkg::addr_t exp_fill_addr;
    int               n_reads;
    int               n_writes;

    cache_top i_cache_top (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #4 clk = ~clk;

    // Untouched memory holds a scrambled copy of its own address
    function automatic logic [31:0] fill_word(input logic [29:0] wa);
        return ({2'b00, wa} * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [29:0] wa);
        return shadow_words.exists(wa) ? shadow_words[wa] : fill_word(wa);
    endfunction

    function automatic cache_pkg::line_u shadow_line(input logic [26:0] la);
        cache_pkg::line_u l;
        for (int w = 0; w < 8; w++) l.words[w] = shadow_word({la, 3'(w)});
        return l;
    endfunction

    function automatic cache_pkg::line_u mem_line(input logic [26:0] la);
        cache_pkg::line_u l;
        for (int w = 0; w < 8; w++) begin
            l.words[w] = mem_words.exists({la, 3'(w)}) ? mem_words[{la, 3'(w)}]
                                                       : fill_word({la, 3'(w)});
        end
        return l;
    endfunction

    function automatic logic [31:0] expand(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [1:0] plru_victim(input logic [2:0] b);
        if (b[2]) return b[0] ? 2'd3 : 2'd2;
        return b[1] ? 2'd1 : 2'd0;
    endfunction

    // Top bit points away from the touched half
    function automatic logic [2:0] plru_touch(input logic [2:0] b, input logic [1:0] w);
        logic [2:0] r;
        r = b;
        r[2] = !w[1];
        if (w[1]) r[0] = !w[0];
        else r[1] = !w[0];
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "cache_tb stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_line(input string name, input cache_pkg::line_u exp,
                              input cache_pkg::line_u act);
        if (act !== exp) stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t exp,
                              input cache_pkg::addr_t act);
        if (act !== exp) stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    // Memory responder, sampled mid cycle
    initial begin
        int delay;
        mem_rsp  = '0;
        n_reads  = 0;
        n_writes = 0;
        forever begin
            @(negedge clk);
            if (!rst && (mem_req.read || mem_req.write)) begin
                if (mem_req.write) begin
                    n_writes++;
                    if (!exp_wb) stop_run("Memory write of a line the model holds as clean");
                    check_addr("writeback_addr", exp_wb_addr, cache_pkg::addr_t'(mem_req.addr));
                    check_line("writeback_line", exp_wb_line, mem_req.wdata);
                    for (int w = 0; w < 8; w++) begin
                        mem_words[{mem_req.addr[31:5], 3'(w)}] = mem_req.wdata.words[w];
                    end
                end else begin
                    n_reads++;
                    check_addr("fill_addr", exp_fill_addr, cache_pkg::addr_t'(mem_req.addr));
                end
                delay = 1 + int'($random(seed) & 3);
                repeat (delay - 1) @(posedge clk);
                @(posedge clk);
                #1;
                mem_rsp.resp  = 1'b1;
                mem_rsp.rdata = mem_line(mem_req.addr[31:5]);
                @(posedge clk);
                #1;
                mem_rsp.resp = 1'b0;
            end
        end
    end

    initial begin
        cache_pkg::addr_t a;
        cache_pkg::addr_t last_wr;
        logic             wr_pending;
        logic             is_wr;
        logic             hit;
        logic [1:0]       way;
        logic [3:0]       s;
        logic [3:0]       mask;
        logic [31:0]      r;
        logic [31:0]      wdata;
        logic [31:0]      old;
        logic [29:0]      wa;
        int               reads0;
        int               writes0;
        int               lat;
        string            name;

        rst           = 1'b1;
        cpu_req       = '0;
        exp_wb        = 1'b0;
        exp_wb_addr   = '0;
        exp_wb_line   = '0;
        exp_fill_addr = '0;
        wr_pending    = 1'b0;
        last_wr       = '0;
        for (int i = 0; i < 16; i++) begin
            m_plru[i] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
                m_tag[i][w]   = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_REQS; i++) begin
            r = $random(seed);
            if (wr_pending && r[31]) begin
                a     = last_wr;  // Read back what was just written
                is_wr = 1'b0;
                name  = "write_then_read";
            end else begin
                a      = '0;
                a.tag  = {20'h002a5, r[2:0]};  // 8 tags over 2 sets, many conflicts
                a.set  = r[3] ? 4'd11 : 4'd4;
                a.word = r[6:4];
                is_wr  = r[7];
                name   = is_wr ? "random_write" : "random_read";
            end
            mask       = (r[11:8] == 4'h0) ? 4'hf : r[11:8];
            wdata      = $random(seed);
            wr_pending = is_wr;
            last_wr    = a;

            // Predict hit or miss, victim and write-back
            s      = a.set;
            hit    = 1'b0;
            way    = 2'd0;
            exp_wb = 1'b0;
            for (int w = 0; w < 4; w++) begin
                if (m_valid[s][w] && m_tag[s][w] == a.tag) begin
                    hit = 1'b1;
                    way = 2'(w);
                end
            end
            if (!hit) begin
                way           = plru_victim(m_plru[s]);
                exp_wb        = m_valid[s][way] && m_dirty[s][way];
                exp_wb_addr   = '{tag: m_tag[s][way], set: s, word: 3'd0, byte_off: 2'd0};
                exp_wb_line   = shadow_line({m_tag[s][way], s});
                exp_fill_addr = '{tag: a.tag, set: s, word: 3'd0, byte_off: 2'd0};
                m_tag[s][way]   = a.tag;
                m_valid[s][way] = 1'b1;
                m_dirty[s][way] = 1'b0;
            end
            m_plru[s] = plru_touch(m_plru[s], way);
            wa  = {a.tag, a.set, a.word};
            old = shadow_word(wa);
            if (is_wr) begin
                shadow_words[wa] = (old & ~expand(mask)) | (wdata & expand(mask));
                m_dirty[s][way]  = 1'b1;
            end

            cpu_req.addr  = a;
            cpu_req.rmask = is_wr ? 4'h0 : mask;
            cpu_req.wmask = is_wr ? mask : 4'h0;
            cpu_req.wdata = wdata;
            reads0  = n_reads;
            writes0 = n_writes;
            lat     = 0;
            do begin
                @(negedge clk);
                lat++;
                if (lat > TIMEOUT) begin
                    stop_run($sformatf("No CPU response within %0d cycles (%s)", TIMEOUT, name));
                end
            end while (!cpu_rsp.resp);

            // A write has no read bytes, so all of rdata reads as zero
            check_word(name, is_wr ? 32'h0 : (old & expand(mask)), cpu_rsp.rdata);
            // First negedge is the request cycle, so a hit answers on the second
            if (hit && (lat != 2 || n_reads != reads0 || n_writes != writes0)) begin
                stop_run($sformatf("Hit took %0d cycles or used memory (%s)", lat - 1, name));
            end
            if (!hit && (n_reads != reads0 + 1 || n_writes != writes0 + int'(exp_wb))) begin
                stop_run($sformatf("Miss made the wrong memory reads or writes (%s)", name));
            end
            @(posedge clk);
            #1;
        end
        cpu_req = '0;

        $display("Test passed");
        $finish;
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    cache_pkg::lookup_t lookup;
    cache_pkg::way_t    victim_way;
    cache_pkg::line_u   victim_line;
    logic [31:0]        victim_addr;
    logic [31:0]        store_rdata;
    logic [31:0]        fill_addr;
    logic               cpu_resp;
    logic               mem_read;
    logic               mem_write;
    logic               write_hit;
    logic               fill;
    logic               touch;

    cache_ctrl i_cache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .lookup     (lookup),
        .victim_way (victim_way),
        .cpu_resp   (cpu_resp),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .write_hit  (write_hit),
        .fill       (fill),
        .touch      (touch),
        .mem_resp   (mem_rsp.resp)
    );

    cache_store i_cache_store (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .victim_way  (victim_way),
        .write_hit   (write_hit),
        .fill        (fill),
        .mem_rdata   (mem_rsp.rdata),
        .lookup      (lookup),
        .rdata       (store_rdata),
        .victim_addr (victim_addr),
        .victim_line (victim_line)
    );

    plru_tree i_plru_tree (
        .clk         (clk),
        .rst         (rst),
        .set         (cpu_req.addr.set),
        .touch       (touch),
        .touched_way (lookup.hit_way),
        .victim_way  (victim_way)
    );

    // Refill reads the requested line, write-back sends the victim's
    assign fill_addr = {cpu_req.addr.tag, cpu_req.addr.set, 5'b0};

    assign cpu_rsp = '{rdata: store_rdata, resp: cpu_resp};
    assign mem_req = '{addr:  (mem_write ? victim_addr : fill_addr),
                       read:  mem_read,
                       write: mem_write,
                       wdata: victim_line};

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    input  cache_pkg::lookup_t  lookup,
    input  cache_pkg::way_t     victim_way,
    output logic                cpu_resp,
    output logic                mem_read,
    output logic                mem_write,
    output logic                write_hit,
    output logic                fill,
    output logic                touch,
    input  logic                mem_resp
);

    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_COMPARE    = 2'd1;
    localparam logic [1:0] ST_WRITE_BACK = 2'd2;
    localparam logic [1:0] ST_ALLOCATE   = 2'd3;

    logic [1:0] state;
    logic [1:0] next_state;
    logic       req_valid;
    logic       is_write;
    logic       hit_resp;

    assign req_valid = |cpu_req.rmask || |cpu_req.wmask;
    assign is_write  = |cpu_req.wmask;
    assign hit_resp  = (state == ST_COMPARE) && req_valid && lookup.hit;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (req_valid) next_state = ST_COMPARE;
            end
            ST_COMPARE: begin
                if (lookup.hit) begin
                    next_state = ST_IDLE;
                end else if (lookup.victim_dirty) begin
                    next_state = ST_WRITE_BACK;  // Evict before refill
                end else begin
                    next_state = ST_ALLOCATE;
                end
            end
            ST_WRITE_BACK: begin
                if (mem_resp) next_state = ST_ALLOCATE;
            end
            ST_ALLOCATE: begin
                if (mem_resp) next_state = ST_COMPARE;  // Retry, now a hit
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign cpu_resp  = hit_resp;
    assign touch     = hit_resp;               // Every hit refreshes the PLRU
    assign write_hit = hit_resp && is_write;
    assign mem_write = (state == ST_WRITE_BACK);
    assign mem_read  = (state == ST_ALLOCATE);
    assign fill      = (state == ST_ALLOCATE) && mem_resp;

    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else $error("cache_ctrl: memory read and write together");

    a_resp_in_compare: assert property (@(posedge clk) disable iff (rst)
        cpu_resp |-> state == ST_COMPARE)
        else $error("cache_ctrl: cpu resp outside compare");

endmodule

// File: logic/plru_tree.sv
`timescale 1ns/1ps

module plru_tree (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      set,
    input  logic            touch,
    input  cache_pkg::way_t touched_way,
    output cache_pkg::way_t victim_way
);

    // Bit 2 is the root, bit 1 picks within ways 0/1, bit 0 within ways 2/3
    logic [2:0] tree_bits [cache_pkg::NUM_SETS];
    logic [2:0] cur_bits;
    logic [2:0] next_bits;

    assign cur_bits = tree_bits[set];

    always_comb begin
        next_bits = cur_bits;
        case (touched_way)
            2'd0: next_bits[2:1] = 2'b11;
            2'd1: next_bits[2:1] = 2'b10;
            2'd2: next_bits      = {1'b0, cur_bits[1], 1'b1};
            2'd3: next_bits      = {1'b0, cur_bits[1], 1'b0};
            default: next_bits   = cur_bits;
        endcase
    end

    // Follow the tree to the victim
    always_comb begin
        if (!cur_bits[2]) begin
            victim_way = cur_bits[1] ? 2'd1 : 2'd0;
        end else begin
            victim_way = cur_bits[0] ? 2'd3 : 2'd2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                tree_bits[s] <= 3'b000;
            end
        end else if (touch) begin
            tree_bits[set] <= next_bits;
        end
    end

endmodule

// File: logic/cache_store.sv
`timescale 1ns/1ps

module cache_store (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::cpu_req_t cpu_req,
    input  cache_pkg::way_t     victim_way,
    input  logic                write_hit,
    input  logic                fill,
    input  cache_pkg::line_u    mem_rdata,
    output cache_pkg::lookup_t  lookup,
    output logic [31:0]         rdata,
    output logic [31:0]         victim_addr,
    output cache_pkg::line_u    victim_line
);

    // Flop arrays, read combinationally by set
    logic [22:0]      tag_arr  [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];
    cache_pkg::line_u data_arr [cache_pkg::NUM_SETS][cache_pkg::NUM_WAYS];

    logic [cache_pkg::NUM_WAYS-1:0] valid_arr [cache_pkg::NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0] dirty_arr [cache_pkg::NUM_SETS];

    logic [3:0]                     set_idx;
    logic [2:0]                     word_idx;
    logic [cache_pkg::NUM_WAYS-1:0] way_hit;
    cache_pkg::line_u               hit_line;
    logic [31:0]                    hit_word;
    logic [31:0]                    rmask_ext;
    logic [31:0]                    wmask_ext;
    logic [31:0]                    merged_word;

    // Expand a byte enable into a bit mask
    function automatic logic [31:0] byte_mask(input logic [3:0] m);
        logic [31:0] r;
        for (int b = 0; b < 4; b++) begin
            r[8*b +: 8] = {8{m[b]}};
        end
        return r;
    endfunction

    assign set_idx  = cpu_req.addr.set;
    assign word_idx = cpu_req.addr.word;

    // Tag compare across all ways
    always_comb begin
        way_hit        = '0;
        lookup.hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            way_hit[w] = valid_arr[set_idx][w] && (tag_arr[set_idx][w] == cpu_req.addr.tag);
            if (way_hit[w]) begin
                lookup.hit_way = cache_pkg::way_t'(w);
            end
        end
        lookup.hit          = |way_hit;
        lookup.victim_dirty = dirty_arr[set_idx][victim_way];
    end

    assign hit_line  = data_arr[set_idx][lookup.hit_way];
    assign hit_word  = hit_line.words[word_idx];
    assign rmask_ext = byte_mask(cpu_req.rmask);
    assign wmask_ext = byte_mask(cpu_req.wmask);

    assign rdata       = hit_word & rmask_ext;  // Unrequested bytes read as zero
    assign merged_word = (hit_word & ~wmask_ext) | (cpu_req.wdata & wmask_ext);

    // Write-back source is always the PLRU victim of the current set
    assign victim_line = data_arr[set_idx][victim_way];
    assign victim_addr = {tag_arr[set_idx][victim_way], set_idx, 5'b0};

    // Payload arrays
    always_ff @(posedge clk) begin
        if (fill) begin
            data_arr[set_idx][victim_way] <= mem_rdata;
            tag_arr[set_idx][victim_way]  <= cpu_req.addr.tag;
        end else if (write_hit) begin
            data_arr[set_idx][lookup.hit_way].words[word_idx] <= merged_word;
        end
    end

    // Line state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
            end
        end else if (fill) begin
            valid_arr[set_idx][victim_way] <= 1'b1;
            dirty_arr[set_idx][victim_way] <= 1'b0;  // Fresh copy of memory
        end else if (write_hit) begin
            dirty_arr[set_idx][lookup.hit_way] <= 1'b1;
        end
    end

    // A fill never installs a tag that already lives in another way
    a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
        else $error("cache_store: more than one way hit");

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    // Cache geometry
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 16;

    typedef logic [1:0] way_t;

    // CPU byte address split into cache fields
    typedef struct packed {
        logic [22:0] tag;
        logic [3:0]  set;
        logic [2:0]  word;      // Word within the 32-byte line
        logic [1:0]  byte_off;  // Zero for aligned accesses
    } addr_t;

    // One line, either as a flat vector or as its eight words
    typedef union packed {
        logic [255:0]     raw;
        logic [7:0][31:0] words;
    } line_u;

    typedef struct packed {
        addr_t       addr;
        logic [3:0]  rmask;     // Nonzero means read
        logic [3:0]  wmask;     // Nonzero means write
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        resp;
    } cpu_rsp_t;

    typedef struct packed {
        logic [31:0] addr;      // Line aligned
        logic        read;
        logic        write;
        line_u       wdata;
    } mem_req_t;

    typedef struct packed {
        line_u rdata;
        logic  resp;
    } mem_rsp_t;

    // Tag compare result handed to the controller
    typedef struct packed {
        logic hit;
        way_t hit_way;
        logic victim_dirty;
    } lookup_t;

endpackage
